// ==== common/link_cfg.svh ====
//----------------------------------------------------------
// Link configuration macros
//   LINK_STAGES  number of delay-line stages (0 or more)
//   LINK_WORD_W  width of one flit word in bits
//----------------------------------------------------------

`ifndef LINK_CFG_SVH
`define LINK_CFG_SVH

// Register stages between the framer and the decoder
// Zero turns the delay line into a plain pass-through
`define LINK_STAGES 4

// One flit carries exactly one 32-bit command or data word
`define LINK_WORD_W 32

`endif

// ==== common/cmd_pkg.sv ====
//----------------------------------------------------------
// Command package
//   cmd_opcode_e   transaction opcodes
//   cmd_fields_t   bit layout of a command word
//----------------------------------------------------------

`include "link_cfg.svh"

package cmd_pkg;

  // Field widths of a command word
  localparam int cmd_len_w  = 4;
  localparam int cmd_tag_w  = 6;
  // The address takes whatever the opcode, length and tag leave over
  localparam int cmd_addr_w = `LINK_WORD_W - 2 - cmd_len_w - cmd_tag_w;

  // Read, fence and nop carry no data beats
  // A write is followed by exactly length data flits
  typedef enum logic [1:0] {
    cmd_nop   = 2'd0,
    cmd_read  = 2'd1,
    cmd_write = 2'd2,
    cmd_fence = 2'd3
  } cmd_opcode_e;

  // Most significant field first
  typedef struct packed {
    cmd_opcode_e                opcode;
    logic [cmd_len_w-1:0]       length;
    logic [cmd_tag_w-1:0]       tag;
    logic [cmd_addr_w-1:0]      addr;
  } cmd_fields_t;

endpackage

// ==== common/flit_pkg.sv ====
//----------------------------------------------------------
// Flit wire format package
//   flit_kind_e   command or data flit
//   flit_word_u   one flit word seen as command fields
//                 or as a raw payload
//----------------------------------------------------------

`include "link_cfg.svh"

package flit_pkg;

  // One bit travels next to every word and says how to read it
  typedef enum logic {
    flit_cmd  = 1'b0,
    flit_data = 1'b1
  } flit_kind_e;

  // Both views must be exactly one link word wide
  // A command layout that drifts from LINK_WORD_W fails to compile here
  typedef union packed {
    cmd_pkg::cmd_fields_t    cmd;
    logic [`LINK_WORD_W-1:0] payload;
  } flit_word_u;

endpackage

// ==== common/flit_if.sv ====
//----------------------------------------------------------
// Flit link interface
//   valid_next strobe one cycle ahead of kind and word
//   src and snk modports, wire-level sanity check
//----------------------------------------------------------

`timescale 1ns/1ps

interface flit_if (
  input logic clk
);
  import flit_pkg::*;

  logic       valid_next;
  flit_kind_e kind;
  flit_word_u word;

  modport src (output valid_next, kind, word);
  modport snk (input valid_next, kind, word);

  // A strobe promises a fully known flit on the next cycle
  flit_known_a : assert property (@(posedge clk)
    valid_next |=> !$isunknown({kind, word}));

endinterface

// ==== hdl/flit_framer.sv ====
//----------------------------------------------------------
// Near-end flit framer
//   Captures input words into a hold register and
//   launches them one cycle after their valid-next
//----------------------------------------------------------

`timescale 1ns/1ps
`include "link_cfg.svh"

module flit_framer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid,
  input  flit_pkg::flit_kind_e    in_kind,
  input  logic [`LINK_WORD_W-1:0] in_word,
  flit_if.src                     link
);
  import flit_pkg::*;

  logic                    valid_next_q;
  flit_kind_e              hold_kind_q;
  logic [`LINK_WORD_W-1:0] hold_word_q;
  flit_kind_e              launch_kind_q;
  flit_word_u              launch_word_q;

  //----------------------------------------------------------
  // Strobe stage
  //----------------------------------------------------------
  // The strobe leaves in the same cycle the word enters the hold register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_next_q <= 1'b0;
    end else begin
      valid_next_q <= in_valid;
    end
  end

  // Hold register only loads on a real input word
  always_ff @(posedge clk) begin
    if (in_valid) begin
      hold_kind_q <= in_kind;
      hold_word_q <= in_word;
    end
  end

  //----------------------------------------------------------
  // Launch stage
  //----------------------------------------------------------
  // The wide word fans out one cycle behind its strobe
  // so that the two wire delays land on different cycles
  always_ff @(posedge clk) begin
    if (valid_next_q) begin
      launch_kind_q         <= hold_kind_q;
      launch_word_q.payload <= hold_word_q;
    end
  end

  assign link.valid_next = valid_next_q;
  assign link.kind       = launch_kind_q;
  assign link.word       = launch_word_q;

  // A new flit only ever appears right behind its own strobe
  launch_after_strobe_a : assert property (@(posedge clk) disable iff (!rst_n)
    $changed({launch_kind_q, launch_word_q}) |-> $past(valid_next_q));

endmodule

// ==== link/link_delay_line.sv ====
//----------------------------------------------------------
// Link delay line
//   Chain of num_stages registers carrying valid-next
//   and the flit, data registers clock-gated by valid-next
//----------------------------------------------------------

`timescale 1ns/1ps

module link_delay_line #(
  // Zero stages makes the block a pass-through
  parameter int num_stages = 0
) (
  input  logic clk,
  input  logic rst_n,
  flit_if.snk  up,
  flit_if.src  dn
);
  import flit_pkg::*;

  // Index 0 is the input side, index num_stages the output side
  logic       stage_valid_next [num_stages+1];
  flit_kind_e stage_kind       [num_stages+1];
  flit_word_u stage_word       [num_stages+1];

  assign stage_valid_next[0] = up.valid_next;
  assign stage_kind[0]       = up.kind;
  assign stage_word[0]       = up.word;

  //----------------------------------------------------------
  // Stage chain
  //----------------------------------------------------------
  for (genvar i = 1; i <= num_stages; i++) begin : gen_stage
    // Strobe registers are cleared so the far end stays quiet after reset
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        stage_valid_next[i] <= 1'b0;
      end else begin
        stage_valid_next[i] <= stage_valid_next[i-1];
      end
    end

    // stage_valid_next[i] high means stage i-1 holds a flit right now
    always_ff @(posedge clk) begin
      if (stage_valid_next[i]) begin
        stage_kind[i] <= stage_kind[i-1];
        stage_word[i] <= stage_word[i-1];
      end
    end
  end

  assign dn.valid_next = stage_valid_next[num_stages];
  assign dn.kind       = stage_kind[num_stages];
  assign dn.word       = stage_word[num_stages];

  //----------------------------------------------------------
  // Latency checks
  //----------------------------------------------------------
  if (num_stages > 0) begin : gen_checks
    valid_next_delay_a : assert property (@(posedge clk) disable iff (!rst_n)
      ##num_stages dn.valid_next == $past(up.valid_next, num_stages));

    // The flit behind each strobe comes out unchanged, num_stages later
    flit_delay_a : assert property (@(posedge clk) disable iff (!rst_n)
      up.valid_next |-> ##num_stages dn.valid_next
        ##1 {dn.kind, dn.word} == $past({up.kind, up.word}, num_stages));
  end

endmodule

// ==== hdl/flit_decoder.sv ====
//----------------------------------------------------------
// Far-end flit decoder
//   Realigns valid with the flit, decodes commands and
//   data beats, tracks write bursts and flags protocol
//   breaks (orphan data, cut bursts)
//----------------------------------------------------------

`timescale 1ns/1ps
`include "link_cfg.svh"

module flit_decoder (
  input  logic                                clk,
  input  logic                                rst_n,
  flit_if.snk                                 link,
  output logic                                cmd_valid,
  output cmd_pkg::cmd_opcode_e                cmd_opcode,
  output logic [cmd_pkg::cmd_len_w-1:0]       cmd_length,
  output logic [cmd_pkg::cmd_tag_w-1:0]       cmd_tag,
  output logic [cmd_pkg::cmd_addr_w-1:0]      cmd_addr,
  output logic                                data_valid,
  output logic [`LINK_WORD_W-1:0]             data_word,
  output logic [cmd_pkg::cmd_len_w-1:0]       data_beat,
  output logic                                burst_done,
  output logic                                orphan_data,
  output logic                                burst_cut
);
  import cmd_pkg::*;
  import flit_pkg::*;

  logic                 valid_q;
  cmd_fields_t          cmd_view;
  logic                 burst_open_q;
  logic [cmd_len_w-1:0] beats_left_q;
  logic [cmd_len_w-1:0] beat_idx_q;

  // Valid-next becomes a valid that lines up with the flit on the wire
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= link.valid_next;
    end
  end

  // Command view of the union, only meaningful for command flits
  assign cmd_view = link.word.cmd;

  //----------------------------------------------------------
  // Pulse outputs and burst state
  //----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_valid    <= 1'b0;
      data_valid   <= 1'b0;
      burst_done   <= 1'b0;
      orphan_data  <= 1'b0;
      burst_cut    <= 1'b0;
      burst_open_q <= 1'b0;
      beats_left_q <= '0;
      beat_idx_q   <= '0;
    end else begin
      // Every strobe lasts exactly one cycle
      cmd_valid   <= 1'b0;
      data_valid  <= 1'b0;
      burst_done  <= 1'b0;
      orphan_data <= 1'b0;
      burst_cut   <= 1'b0;
      if (valid_q && link.kind == flit_cmd) begin
        cmd_valid <= 1'b1;
        // Any command ends a burst that is still waiting for beats
        burst_cut    <= burst_open_q;
        burst_open_q <= 1'b0;
        if (cmd_view.opcode == cmd_write) begin
          if (cmd_view.length == '0) begin
            burst_done <= 1'b1;
          end else begin
            burst_open_q <= 1'b1;
            beats_left_q <= cmd_view.length;
            beat_idx_q   <= '0;
          end
        end
      end else if (valid_q) begin
        if (burst_open_q) begin
          data_valid   <= 1'b1;
          beat_idx_q   <= beat_idx_q + 1'b1;
          beats_left_q <= beats_left_q - 1'b1;
          // Last expected beat closes the burst
          if (beats_left_q == cmd_len_w'(1)) begin
            burst_done   <= 1'b1;
            burst_open_q <= 1'b0;
          end
        end else begin
          orphan_data <= 1'b1;
        end
      end
    end
  end

  // Payload outputs follow their strobe and need no clearing
  always_ff @(posedge clk) begin
    if (valid_q && link.kind == flit_cmd) begin
      cmd_opcode <= cmd_view.opcode;
      cmd_length <= cmd_view.length;
      cmd_tag    <= cmd_view.tag;
      cmd_addr   <= cmd_view.addr;
    end
    if (valid_q && link.kind == flit_data) begin
      data_word <= link.word.payload;
      data_beat <= beat_idx_q;
    end
  end

  //----------------------------------------------------------
  // Protocol checks
  //----------------------------------------------------------
  one_event_a : assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_valid && data_valid));

  // Done comes from a zero-length write or from a beat of a burst
  // that a write opened earlier
  done_has_write_a : assert property (@(posedge clk) disable iff (!rst_n)
    burst_done |-> (cmd_valid && cmd_opcode == cmd_write && cmd_length == '0)
                   || (data_valid && $past(burst_open_q)));

endmodule

// ==== hdl/flit_link_top.sv ====
//----------------------------------------------------------
// Flit link top level
//   Framer, delay line and decoder in a chain,
//   joined by two flit_if bundles
//----------------------------------------------------------

`timescale 1ns/1ps
`include "link_cfg.svh"

module flit_link_top (
  input  logic                                clk,
  input  logic                                rst_n,
  // Near end, one word per in_valid strobe
  input  logic                                in_valid,
  input  flit_pkg::flit_kind_e                in_kind,
  input  logic [`LINK_WORD_W-1:0]             in_word,
  // Far end, one pulse per word, LINK_STAGES+2 cycles later
  output logic                                cmd_valid,
  output cmd_pkg::cmd_opcode_e                cmd_opcode,
  output logic [cmd_pkg::cmd_len_w-1:0]       cmd_length,
  output logic [cmd_pkg::cmd_tag_w-1:0]       cmd_tag,
  output logic [cmd_pkg::cmd_addr_w-1:0]      cmd_addr,
  output logic                                data_valid,
  output logic [`LINK_WORD_W-1:0]             data_word,
  output logic [cmd_pkg::cmd_len_w-1:0]       data_beat,
  output logic                                burst_done,
  output logic                                orphan_data,
  output logic                                burst_cut
);

  // Framer to delay line, and delay line to decoder
  flit_if link_a (.clk(clk));
  flit_if link_b (.clk(clk));

  flit_framer flit_framer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_kind  (in_kind),
    .in_word  (in_word),
    .link     (link_a.src)
  );

  // The long wire run lives here
  link_delay_line #(
    .num_stages (`LINK_STAGES)
  ) link_delay_line_i (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (link_a.snk),
    .dn    (link_b.src)
  );

  flit_decoder flit_decoder_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .link        (link_b.snk),
    .cmd_valid   (cmd_valid),
    .cmd_opcode  (cmd_opcode),
    .cmd_length  (cmd_length),
    .cmd_tag     (cmd_tag),
    .cmd_addr    (cmd_addr),
    .data_valid  (data_valid),
    .data_word   (data_word),
    .data_beat   (data_beat),
    .burst_done  (burst_done),
    .orphan_data (orphan_data),
    .burst_cut   (burst_cut)
  );

endmodule

// ==== sim/flit_link_checker.sv ====
//----------------------------------------------------------
// Flit link checker
//   Reference model of the decoding and burst rules,
//   queue of expected output events with due cycles,
//   per-cycle comparison of the DUT output pulses
//----------------------------------------------------------

`timescale 1ns/1ps
`include "link_cfg.svh"

module flit_link_checker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          in_valid,
  input  flit_pkg::flit_kind_e          in_kind,
  input  logic [`LINK_WORD_W-1:0]       in_word,
  input  logic                          cmd_valid,
  input  logic [1:0]                    cmd_opcode,
  input  logic [3:0]                    cmd_length,
  input  logic [5:0]                    cmd_tag,
  input  logic [`LINK_WORD_W-13:0]      cmd_addr,
  input  logic                          data_valid,
  input  logic [`LINK_WORD_W-1:0]       data_word,
  input  logic [3:0]                    data_beat,
  input  logic                          burst_done,
  input  logic                          orphan_data,
  input  logic                          burst_cut,
  output int                            err_count,
  output int                            check_count,
  output int                            pending
);
  import cmd_pkg::*;
  import flit_pkg::*;

  localparam int word_w = `LINK_WORD_W;
  localparam int addr_w = `LINK_WORD_W - 12;

  // One expected far-end event and the cycle it must show up in
  typedef struct {
    int                 due;
    logic               cmd_valid;
    logic [1:0]         opcode;
    logic [3:0]         length;
    logic [5:0]         tag;
    logic [addr_w-1:0]  addr;
    logic               data_valid;
    logic [word_w-1:0]  data_word;
    logic [3:0]         data_beat;
    logic               burst_done;
    logic               orphan_data;
    logic               burst_cut;
  } event_t;

  event_t exp_q[$];
  int     cycle = 0;

  // Burst state of the reference model
  logic       burst_open;
  logic [3:0] beats_left;
  logic [3:0] next_beat;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //----------------------------------------------------------
  // Reference model
  //----------------------------------------------------------
  // Command layout from the top: opcode 2, length 4, tag 6, address
  function automatic event_t predict(input flit_kind_e kind, input logic [word_w-1:0] word);
    event_t ev;
    ev = '{default: 0};
    if (kind == flit_cmd) begin
      ev.cmd_valid = 1'b1;
      ev.opcode    = word[word_w-1 -: 2];
      ev.length    = word[word_w-3 -: 4];
      ev.tag       = word[word_w-7 -: 6];
      ev.addr      = word[addr_w-1:0];
      // A command always closes whatever burst was still open
      ev.burst_cut = burst_open;
      burst_open   = 1'b0;
      if (ev.opcode == cmd_write) begin
        if (ev.length == 4'd0) begin
          ev.burst_done = 1'b1;
        end else begin
          burst_open = 1'b1;
          beats_left = ev.length;
          next_beat  = 4'd0;
        end
      end
    end else if (burst_open) begin
      ev.data_valid = 1'b1;
      ev.data_word  = word;
      ev.data_beat  = next_beat;
      next_beat     = next_beat + 4'd1;
      beats_left    = beats_left - 4'd1;
      if (beats_left == 4'd0) begin
        ev.burst_done = 1'b1;
        burst_open    = 1'b0;
      end
    end else begin
      ev.orphan_data = 1'b1;
    end
    return ev;
  endfunction

  //----------------------------------------------------------
  // Comparison
  //----------------------------------------------------------
  task automatic report_mismatch(input string msg);
    err_count++;
    $display("mismatch at time %0t: %s", $time, msg);
  endtask

  task automatic check_strobe(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      if (exp) begin
        $display("missing %s pulse at time %0t", name, $time);
      end else begin
        $display("unexpected %s pulse at time %0t", name, $time);
      end
    end
  endtask

  task automatic compare_event(input event_t ev);
    check_strobe("cmd_valid", cmd_valid, ev.cmd_valid);
    check_strobe("data_valid", data_valid, ev.data_valid);
    check_strobe("burst_done", burst_done, ev.burst_done);
    check_strobe("orphan_data", orphan_data, ev.orphan_data);
    check_strobe("burst_cut", burst_cut, ev.burst_cut);
    if (ev.cmd_valid && cmd_valid === 1'b1 &&
        {cmd_opcode, cmd_length, cmd_tag, cmd_addr} !==
        {ev.opcode, ev.length, ev.tag, ev.addr}) begin
      report_mismatch($sformatf("command op %0d len %0d tag %0h addr %0h, expected %0d %0d %0h %0h",
        cmd_opcode, cmd_length, cmd_tag, cmd_addr, ev.opcode, ev.length, ev.tag, ev.addr));
    end
    if (ev.data_valid && data_valid === 1'b1 &&
        {data_word, data_beat} !== {ev.data_word, ev.data_beat}) begin
      report_mismatch($sformatf("data %h beat %0d, expected %h beat %0d",
        data_word, data_beat, ev.data_word, ev.data_beat));
    end
  endtask

  // Inputs and outputs are both settled at the falling edge
  // An input seen here is sampled at the next rising edge
  always @(negedge clk) begin : compare_proc
    event_t ev;
    if (!rst_n) begin
      burst_open = 1'b0;
      beats_left = 4'd0;
      next_beat  = 4'd0;
      exp_q.delete();
    end else begin
      if (in_valid === 1'b1) begin
        ev     = predict(in_kind, in_word);
        ev.due = cycle + `LINK_STAGES + 3;
        exp_q.push_back(ev);
      end
      if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
        ev = exp_q.pop_front();
        check_count++;
      end else begin
        // Nothing due, so every strobe has to stay low
        ev = '{default: 0};
      end
      compare_event(ev);
    end
    pending = exp_q.size();
  end

endmodule

// ==== sim/flit_link_tb.sv ====
//----------------------------------------------------------
// Flit link testbench
//   Clock, reset, directed tests, seeded random traffic,
//   watchdog and the final verdict
//----------------------------------------------------------

`timescale 1ns/1ps
`include "link_cfg.svh"

module flit_link_tb;
  import cmd_pkg::*;
  import flit_pkg::*;

  localparam int clk_period = 20;
  localparam int reset_cycles = 3;
  // Directed tests, then the random run
  localparam int stim_cycles = 20 + 13 + 6 + 2 + 3 + 300;
  // Each test drains the pipe before it reports
  localparam int drain_cycles = 6 * (`LINK_STAGES + 4);
  localparam int timeout_cycles =
    reset_cycles + stim_cycles + drain_cycles + `LINK_STAGES + 50;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     in_valid;
  flit_kind_e               in_kind;
  logic [`LINK_WORD_W-1:0]  in_word;
  logic                     cmd_valid;
  cmd_opcode_e              cmd_opcode;
  logic [3:0]               cmd_length;
  logic [5:0]               cmd_tag;
  logic [`LINK_WORD_W-13:0] cmd_addr;
  logic                     data_valid;
  logic [`LINK_WORD_W-1:0]  data_word;
  logic [3:0]               data_beat;
  logic                     burst_done;
  logic                     orphan_data;
  logic                     burst_cut;
  int                       err_count;
  int                       check_count;
  int                       pending;
  int                       errors_before = 0;
  integer                   seed = 32'hf2a2_1076;

  always #(clk_period / 2) clk = ~clk;

  flit_link_top flit_link_top_i (.*);

  flit_link_checker flit_link_checker_i (.*);

  //----------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------
  function automatic logic [`LINK_WORD_W-1:0] make_cmd(input cmd_opcode_e op,
      input logic [3:0] len, input logic [5:0] tag, input logic [`LINK_WORD_W-13:0] addr);
    return {op, len, tag, addr};
  endfunction

  // One word per call, back to back when called in a row
  task automatic send(input flit_kind_e kind, input logic [`LINK_WORD_W-1:0] word);
    in_valid = 1'b1;
    in_kind  = kind;
    in_word  = word;
    @(posedge clk);
    #2;
    in_valid = 1'b0;
  endtask

  task automatic idle(input int cycles);
    in_valid = 1'b0;
    repeat (cycles) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Waits until every expected event has been compared
  task automatic end_test(input int num, input string name);
    @(negedge clk);
    #1;
    while (pending != 0) begin
      @(negedge clk);
      #1;
    end
    $display("test %0d %s: done, %0d errors", num, name, err_count - errors_before);
    errors_before = err_count;
    @(posedge clk);
    #2;
  endtask

  //----------------------------------------------------------
  // Tests
  //----------------------------------------------------------
  initial begin : stimulus
    logic [31:0]             r;
    logic [`LINK_WORD_W-1:0] w;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_kind  = flit_cmd;
    in_word  = '0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;

    idle(20);
    end_test(1, "no pulses after reset");

    send(flit_cmd, make_cmd(cmd_read, 4'd0, 6'h11, 20'h0_1234));
    idle(5);
    send(flit_cmd, make_cmd(cmd_fence, 4'd0, 6'h22, 20'h0_0000));
    idle(5);
    send(flit_cmd, make_cmd(cmd_nop, 4'd7, 6'h33, 20'hf_ffff));
    end_test(2, "single commands");

    send(flit_cmd, make_cmd(cmd_write, 4'd5, 6'h05, 20'h4_0000));
    for (int i = 0; i < 5; i++) begin
      send(flit_data, 32'hd000_0000 + i);
    end
    end_test(3, "back-to-back write burst");

    send(flit_cmd, make_cmd(cmd_write, 4'd0, 6'h06, 20'h5_0000));
    send(flit_data, 32'hdead_beef);
    end_test(4, "zero-length write and orphan data");

    send(flit_cmd, make_cmd(cmd_write, 4'd3, 6'h07, 20'h6_0000));
    send(flit_data, 32'h1111_2222);
    send(flit_cmd, make_cmd(cmd_read, 4'd0, 6'h08, 20'h7_0000));
    end_test(5, "cut burst");

    // Mostly busy cycles, short bursts so that many of them complete
    for (int i = 0; i < 300; i++) begin
      r = $random(seed);
      w = $random(seed);
      if (r[1:0] == 2'b00) begin
        idle(1);
      end else if (r[2]) begin
        send(flit_data, w);
      end else begin
        send(flit_cmd, make_cmd(cmd_opcode_e'(r[4:3]), {2'b00, r[6:5]}, w[25:20], w[19:0]));
      end
    end
    end_test(6, "random mixed traffic");

    $display("tests: 6, checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeout_cycles * clk_period);
    $display("watchdog expired: tests did not finish within %0d cycles", timeout_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== flit_link_top.f ====
+incdir+common
common/cmd_pkg.sv
common/flit_pkg.sv
common/flit_if.sv
hdl/flit_framer.sv
link/link_delay_line.sv
hdl/flit_decoder.sv
hdl/flit_link_top.sv
sim/flit_link_checker.sv
sim/flit_link_tb.sv

// ==== Bender.yml ====
package:
  name: flit_link

export_include_dirs:
  - common

sources:
  # Synthesizable link, also compiled for simulation
  - target: any(rtl, simulation)
    include_dirs:
      - common
    files:
      - common/cmd_pkg.sv
      - common/flit_pkg.sv
      - common/flit_if.sv
      - hdl/flit_framer.sv
      - link/link_delay_line.sv
      - hdl/flit_decoder.sv
      - hdl/flit_link_top.sv
  # Testbench and checker
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/flit_link_checker.sv
      - sim/flit_link_tb.sv
